// File: source/sc_pkg.sv
package sc_pkg;

  // datapath widths
  localparam int arg_w = 32;
  localparam int data_w = 8;
  localparam int cnt_w = 16;

  // apb slave
  localparam int apb_addr_w = 4;
  localparam int apb_data_w = 32;

  localparam logic [apb_addr_w-1:0] addr_ctrl = apb_addr_w'(0);
  localparam logic [apb_addr_w-1:0] addr_cnt_a = apb_addr_w'(4);
  localparam logic [apb_addr_w-1:0] addr_cnt_b = apb_addr_w'(8);
  localparam logic [apb_addr_w-1:0] addr_status = apb_addr_w'(12);

  // arbitration mode bit
  localparam logic mode_fixed = 1'b0;
  localparam logic mode_rr = 1'b1;

  // owner encoding, also used on grant_owner
  localparam logic owner_a = 1'b0;
  localparam logic owner_b = 1'b1;

  // checksum engine, one byte per cycle
  localparam int engine_cycles = 4;
  localparam int engine_cnt_w = $clog2(engine_cycles) + 1;

  // arbiter fsm encoding
  localparam int state_w = 2;
  localparam logic [state_w-1:0] st_idle = 2'd0;
  localparam logic [state_w-1:0] st_run = 2'd1;
  localparam logic [state_w-1:0] st_done = 2'd2;

endpackage

// File: source/shared_access_to_one_current_state_machine.sv
`timescale 1ns/10ps

module shared_access_to_one_current_state_machine (
  input  logic                      sm_clk,
  input  logic                      rst,
  input  logic                      enable,
  input  logic                      mode,
  input  logic                      start_request_a,
  input  logic                      start_request_b,
  input  logic [sc_pkg::arg_w-1:0]  input_arguments_a,
  input  logic [sc_pkg::arg_w-1:0]  input_arguments_b,
  input  logic                      target_current_state_machine_finished,
  input  logic [sc_pkg::data_w-1:0] in_received_data,
  output logic [sc_pkg::arg_w-1:0]  output_arguments,
  output logic                      start_target_current_state_machine,
  output logic                      finish_a,
  output logic                      finish_b,
  output logic                      reset_start_request_a,
  output logic                      reset_start_request_b,
  output logic [sc_pkg::data_w-1:0] received_data_a,
  output logic [sc_pkg::data_w-1:0] received_data_b,
  output logic                      grant_pulse,
  output logic                      grant_owner,
  output logic                      busy,
  output logic                      last_owner
);

  import sc_pkg::*;

  logic [state_w-1:0] state;
  logic               owner; // current or most recent owner
  logic               req_any;
  logic               winner;
  logic               grant;

  assign req_any = start_request_a || start_request_b;

  // pick the client to serve when both may be pending
  always_comb begin
    if (start_request_a && start_request_b) begin
      if (mode == mode_fixed) begin
        winner = owner_a;
      end else begin
        winner = (owner == owner_a) ? owner_b : owner_a; // the one not served last
      end
    end else if (start_request_a) begin
      winner = owner_a;
    end else begin
      winner = owner_b;
    end
  end

  assign grant = (state == st_idle) && enable && req_any;

  always_ff @(posedge sm_clk) begin
    if (rst) begin
      state <= st_idle;
      start_target_current_state_machine <= 1'b0;
      owner <= owner_b; // so round robin favours a first
    end else begin
      start_target_current_state_machine <= 1'b0;
      case (state)
        st_idle: begin
          if (grant) begin
            state <= st_run;
            start_target_current_state_machine <= 1'b1;
            owner <= winner;
          end
        end
        st_run: begin
          if (target_current_state_machine_finished) begin
            state <= st_done;
          end
        end
        st_done: begin
          state <= st_idle; // finish pulse lasts one cycle
        end
        default: begin
          state <= st_idle;
        end
      endcase
    end
  end

  // argument stays put for the whole job
  always_ff @(posedge sm_clk) begin
    if (grant) begin
      output_arguments <= (winner == owner_a) ? input_arguments_a : input_arguments_b;
    end
  end

  // result held until that client's next completion
  always_ff @(posedge sm_clk) begin
    if ((state == st_run) && target_current_state_machine_finished) begin
      if (owner == owner_a) begin
        received_data_a <= in_received_data;
      end else begin
        received_data_b <= in_received_data;
      end
    end
  end

  assign finish_a = (state == st_done) && (owner == owner_a);
  assign finish_b = (state == st_done) && (owner == owner_b);
  assign reset_start_request_a = finish_a; // clears the client request
  assign reset_start_request_b = finish_b;

  assign grant_pulse = start_target_current_state_machine;
  assign grant_owner = owner;
  assign busy = (state != st_idle);
  assign last_owner = owner;

  a_start_single: assert property (
    @(posedge sm_clk) disable iff (rst)
    start_target_current_state_machine |=> !start_target_current_state_machine
  ) else $error("start held for more than one cycle");

  a_finish_onehot: assert property (
    @(posedge sm_clk) disable iff (rst)
    !(finish_a && finish_b)
  ) else $error("both clients finished together");

  // engine must only complete a job we started
  a_no_finish_idle: assert property (
    @(posedge sm_clk) disable iff (rst)
    target_current_state_machine_finished |-> (state != st_idle)
  ) else $error("engine finished while arbiter idle");

endmodule

// File: source/checksum_engine.sv
`timescale 1ns/10ps

module checksum_engine (
  input  logic                      sm_clk,
  input  logic                      rst,
  input  logic                      start,
  input  logic [sc_pkg::arg_w-1:0]  arguments,
  output logic                      finished,
  output logic [sc_pkg::data_w-1:0] result
);

  import sc_pkg::*;

  logic                    running;
  logic [engine_cnt_w-1:0] byte_cnt; // bytes already summed
  logic [arg_w-1:0]        shift_q;
  logic [data_w-1:0]       acc;

  // control, finished lands engine_cycles after start
  always_ff @(posedge sm_clk) begin
    if (rst) begin
      running <= 1'b0;
      byte_cnt <= '0;
      finished <= 1'b0;
    end else begin
      finished <= 1'b0;
      if (start) begin
        running <= 1'b1;
        byte_cnt <= engine_cnt_w'(1); // byte 0 taken on the start edge
      end else if (running) begin
        byte_cnt <= byte_cnt + 1'b1;
        if (byte_cnt == engine_cnt_w'(engine_cycles - 1)) begin
          running <= 1'b0;
          finished <= 1'b1;
        end
      end
    end
  end

  // datapath, lowest byte first
  always_ff @(posedge sm_clk) begin
    if (start) begin
      acc <= arguments[data_w-1:0];
      shift_q <= arguments >> data_w;
    end else if (running) begin
      acc <= acc + shift_q[data_w-1:0]; // wraps mod 256
      shift_q <= shift_q >> data_w;
    end
  end

  assign result = acc;

  // the arbiter has to wait for finished before the next job
  a_start_when_free: assert property (
    @(posedge sm_clk) disable iff (rst)
    start |-> !running
  ) else $error("start while engine busy");

endmodule

// File: source/sm_share_regs.sv
`timescale 1ns/10ps

module sm_share_regs (
  input  logic                          sm_clk,
  input  logic                          rst,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [sc_pkg::apb_addr_w-1:0] paddr,
  input  logic [sc_pkg::apb_data_w-1:0] pwdata,
  input  logic                          grant_pulse,
  input  logic                          grant_owner,
  input  logic                          busy,
  input  logic                          last_owner,
  output logic [sc_pkg::apb_data_w-1:0] prdata,
  output logic                          pready,
  output logic                          pslverr,
  output logic                          enable,
  output logic                          mode
);

  import sc_pkg::*;

  logic             wr_en;
  logic             inc_a;
  logic             inc_b;
  logic [cnt_w-1:0] cnt_a;
  logic [cnt_w-1:0] cnt_b;

  // clear beats increment, counter sticks at max
  function automatic logic [cnt_w-1:0] next_cnt(
    input logic [cnt_w-1:0] cur,
    input logic             clr,
    input logic             inc
  );
    logic [cnt_w-1:0] nxt;
    nxt = cur;
    if (clr) begin
      nxt = '0;
    end else if (inc && (cur != '1)) begin
      nxt = cur + 1'b1;
    end
    return nxt;
  endfunction

  assign wr_en = psel && penable && pwrite; // no wait states
  assign inc_a = grant_pulse && (grant_owner == owner_a);
  assign inc_b = grant_pulse && (grant_owner == owner_b);

  always_ff @(posedge sm_clk) begin
    if (rst) begin
      enable <= 1'b1;
      mode <= mode_fixed;
    end else if (wr_en && (paddr == addr_ctrl)) begin
      enable <= pwdata[0];
      mode <= pwdata[1];
    end
  end

  always_ff @(posedge sm_clk) begin
    if (rst) begin
      cnt_a <= '0;
      cnt_b <= '0;
    end else begin
      cnt_a <= next_cnt(cnt_a, wr_en && (paddr == addr_cnt_a), inc_a);
      cnt_b <= next_cnt(cnt_b, wr_en && (paddr == addr_cnt_b), inc_b);
    end
  end

  // read mux
  always_comb begin
    case (paddr)
      addr_ctrl: begin
        prdata = {{(apb_data_w - 2){1'b0}}, mode, enable};
      end
      addr_cnt_a: begin
        prdata = {{(apb_data_w - cnt_w){1'b0}}, cnt_a};
      end
      addr_cnt_b: begin
        prdata = {{(apb_data_w - cnt_w){1'b0}}, cnt_b};
      end
      addr_status: begin
        prdata = {{(apb_data_w - 2){1'b0}}, last_owner, busy};
      end
      default: begin
        prdata = '0; // unmapped
      end
    endcase
  end

  assign pready = 1'b1;
  assign pslverr = 1'b0;

  a_penable_psel: assert property (
    @(posedge sm_clk) disable iff (rst)
    penable |-> psel
  ) else $error("penable without psel");

endmodule

// File: source/sm_share_top.sv
`timescale 1ns/10ps

module sm_share_top (
  input  logic                          sm_clk,
  input  logic                          rst,
  input  logic                          psel,
  input  logic                          penable,
  input  logic                          pwrite,
  input  logic [sc_pkg::apb_addr_w-1:0] paddr,
  input  logic [sc_pkg::apb_data_w-1:0] pwdata,
  output logic [sc_pkg::apb_data_w-1:0] prdata,
  output logic                          pready,
  output logic                          pslverr,
  input  logic                          start_request_a,
  input  logic [sc_pkg::arg_w-1:0]      input_arguments_a,
  output logic                          finish_a,
  output logic                          reset_start_request_a,
  output logic [sc_pkg::data_w-1:0]     received_data_a,
  input  logic                          start_request_b,
  input  logic [sc_pkg::arg_w-1:0]      input_arguments_b,
  output logic                          finish_b,
  output logic                          reset_start_request_b,
  output logic [sc_pkg::data_w-1:0]     received_data_b
);

  import sc_pkg::*;

  logic              enable;
  logic              mode;
  logic              grant_pulse;
  logic              grant_owner;
  logic              busy;
  logic              last_owner;
  logic              eng_start;
  logic              eng_finished;
  logic [arg_w-1:0]  eng_args;
  logic [data_w-1:0] eng_result;

  sm_share_regs regs0 (
    .sm_clk      (sm_clk),
    .rst         (rst),
    .psel        (psel),
    .penable     (penable),
    .pwrite      (pwrite),
    .paddr       (paddr),
    .pwdata      (pwdata),
    .grant_pulse (grant_pulse),
    .grant_owner (grant_owner),
    .busy        (busy),
    .last_owner  (last_owner),
    .prdata      (prdata),
    .pready      (pready),
    .pslverr     (pslverr),
    .enable      (enable),
    .mode        (mode)
  );

  shared_access_to_one_current_state_machine arb0 (
    .sm_clk                                (sm_clk),
    .rst                                   (rst),
    .enable                                (enable),
    .mode                                  (mode),
    .start_request_a                       (start_request_a),
    .start_request_b                       (start_request_b),
    .input_arguments_a                     (input_arguments_a),
    .input_arguments_b                     (input_arguments_b),
    .target_current_state_machine_finished (eng_finished),
    .in_received_data                      (eng_result),
    .output_arguments                      (eng_args),
    .start_target_current_state_machine    (eng_start),
    .finish_a                              (finish_a),
    .finish_b                              (finish_b),
    .reset_start_request_a                 (reset_start_request_a),
    .reset_start_request_b                 (reset_start_request_b),
    .received_data_a                       (received_data_a),
    .received_data_b                       (received_data_b),
    .grant_pulse                           (grant_pulse),
    .grant_owner                           (grant_owner),
    .busy                                  (busy),
    .last_owner                            (last_owner)
  );

  checksum_engine eng0 (
    .sm_clk    (sm_clk),
    .rst       (rst),
    .start     (eng_start),
    .arguments (eng_args),
    .finished  (eng_finished),
    .result    (eng_result)
  );

endmodule

// File: test/sm_share_tb.sv
`timescale 1ns/10ps

module sm_share_tb;

  import sc_pkg::*;

  localparam int job_limit = 100; // cycles a client waits for reset-start
  localparam int apb_limit = 16;

  logic                  sm_clk;
  logic                  rst;
  logic                  psel;
  logic                  penable;
  logic                  pwrite;
  logic [apb_addr_w-1:0] paddr;
  logic [apb_data_w-1:0] pwdata;
  logic [apb_data_w-1:0] prdata;
  logic                  pready;
  logic                  pslverr;
  logic                  start_request_a;
  logic [arg_w-1:0]      input_arguments_a;
  logic                  finish_a;
  logic                  reset_start_request_a;
  logic [data_w-1:0]     received_data_a;
  logic                  start_request_b;
  logic [arg_w-1:0]      input_arguments_b;
  logic                  finish_b;
  logic                  reset_start_request_b;
  logic [data_w-1:0]     received_data_b;

  int          n_err;
  int          n_tmo;
  logic [31:0] lfsr;
  logic [arg_w-1:0] arg_x;
  logic [arg_w-1:0] arg_y;

  // reference model
  logic              m_busy;
  int                m_left; // cycles until the expected finish
  logic              m_owner;
  logic              m_last;
  logic              m_enable;
  logic              m_mode;
  logic [data_w-1:0] m_exp;
  logic [cnt_w-1:0]  m_cnt_a;
  logic [cnt_w-1:0]  m_cnt_b;
  logic              m_inc_a; // grant seen, counter moves next edge
  logic              m_inc_b;
  logic              fin_due;
  logic              win;
  logic              new_inc_a;
  logic              new_inc_b;
  logic              apb_rd;
  logic              apb_wr;

  sm_share_top dut0 (
    .sm_clk                (sm_clk),
    .rst                   (rst),
    .psel                  (psel),
    .penable               (penable),
    .pwrite                (pwrite),
    .paddr                 (paddr),
    .pwdata                (pwdata),
    .prdata                (prdata),
    .pready                (pready),
    .pslverr               (pslverr),
    .start_request_a       (start_request_a),
    .input_arguments_a     (input_arguments_a),
    .finish_a              (finish_a),
    .reset_start_request_a (reset_start_request_a),
    .received_data_a       (received_data_a),
    .start_request_b       (start_request_b),
    .input_arguments_b     (input_arguments_b),
    .finish_b              (finish_b),
    .reset_start_request_b (reset_start_request_b),
    .received_data_b       (received_data_b)
  );

  always #4 sm_clk = ~sm_clk;

  // fibonacci lfsr, taps 32 22 2 1, one step per bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    logic        fb;
    int          i;
    v = '0;
    for (i = 0; i < n; i++) begin
      fb = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      v = {v[30:0], fb};
    end
    return v;
  endfunction

  function automatic logic [data_w-1:0] byte_sum(input logic [arg_w-1:0] arg);
    logic [data_w-1:0] s;
    int                i;
    s = '0;
    for (i = 0; i < arg_w / data_w; i++) begin
      s = s + arg[i*data_w +: data_w]; // wraps mod 256
    end
    return s;
  endfunction

  task automatic check_data(input logic [data_w-1:0] got, input logic [data_w-1:0] exp,
                            input string what);
    if (got !== exp) begin
      n_err++;
      $display("** Error at %0d ns: %s is %02h, expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input logic [cnt_w-1:0] got, input logic [cnt_w-1:0] exp,
                             input string what);
    if (got !== exp) begin
      n_err++;
      $display("** Error at %0d ns: %s is %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic check_owner(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      n_err++;
      $display("** Error at %0d ns: %s is client %s, expected client %s", $time, what,
               (got == owner_a) ? "a" : "b", (exp == owner_a) ? "a" : "b");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      n_err++;
      $display("** Error at %0d ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic apb_access(input logic wr, input logic [apb_addr_w-1:0] addr,
                            input logic [apb_data_w-1:0] data);
    int   waited;
    logic done;
    @(negedge sm_clk);
    psel = 1'b1;
    penable = 1'b0;
    pwrite = wr;
    paddr = addr;
    pwdata = data;
    @(negedge sm_clk);
    penable = 1'b1;
    done = 1'b0;
    waited = 0;
    while (!done && waited < apb_limit) begin
      @(posedge sm_clk);
      waited++;
      done = pready;
    end
    if (!done) begin
      n_tmo++;
      $display("timeout: APB access to address %0d never saw pready", addr);
    end
    @(negedge sm_clk);
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
  endtask

  task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [apb_data_w-1:0] data);
    apb_access(1'b1, addr, data);
  endtask

  task automatic apb_read(input logic [apb_addr_w-1:0] addr);
    apb_access(1'b0, addr, '0); // read data is checked by the model monitor
  endtask

  // one request, held until reset-start is seen, dropped a cycle later
  task automatic client_job(input logic who, input logic [arg_w-1:0] arg);
    int   waited;
    logic seen;
    @(negedge sm_clk);
    if (who == owner_a) begin
      start_request_a = 1'b1;
      input_arguments_a = arg;
    end else begin
      start_request_b = 1'b1;
      input_arguments_b = arg;
    end
    seen = 1'b0;
    waited = 0;
    while (!seen && waited < job_limit) begin
      @(posedge sm_clk);
      waited++;
      seen = (who == owner_a) ? reset_start_request_a : reset_start_request_b;
    end
    if (!seen) begin
      n_tmo++;
      $display("timeout: client %s hung waiting for reset_start_request",
               (who == owner_a) ? "a" : "b");
    end
    @(negedge sm_clk);
    if (who == owner_a) begin
      start_request_a = 1'b0;
    end else begin
      start_request_b = 1'b0;
    end
  endtask

  task automatic client_stream(input logic who, input int n);
    int               i;
    logic [arg_w-1:0] arg;
    for (i = 0; i < n; i++) begin
      repeat (rand_bits(3)) @(negedge sm_clk);
      arg = rand_bits(arg_w);
      client_job(who, arg);
    end
  endtask

  task automatic both_at_once();
    arg_x = rand_bits(arg_w);
    arg_y = rand_bits(arg_w);
    fork
      client_job(owner_a, arg_x);
      client_job(owner_b, arg_y);
    join
  endtask

  // model runs on the same edges the DUT samples
  always @(posedge sm_clk) begin
    if (rst) begin
      m_busy = 1'b0;
      m_left = 0;
      m_owner = owner_a;
      m_last = owner_b;
      m_enable = 1'b1;
      m_mode = mode_fixed;
      m_exp = '0;
      m_cnt_a = '0;
      m_cnt_b = '0;
      m_inc_a = 1'b0;
      m_inc_b = 1'b0;
    end else begin
      apb_rd = psel && penable && !pwrite;
      apb_wr = psel && penable && pwrite;
      if (psel && penable) begin
        check_flag(pready, 1'b1, "pready"); // no wait states
        check_flag(pslverr, 1'b0, "pslverr");
      end
      if (apb_rd) begin
        case (paddr)
          addr_ctrl: begin
            check_flag(prdata[0], m_enable, "ctrl enable");
            check_flag(prdata[1], m_mode, "ctrl mode");
          end
          addr_cnt_a: check_count(prdata[cnt_w-1:0], m_cnt_a, "grant counter a");
          addr_cnt_b: check_count(prdata[cnt_w-1:0], m_cnt_b, "grant counter b");
          addr_status: begin
            check_flag(prdata[0], m_busy, "status busy");
            check_owner(prdata[1], m_last, "status last_owner");
          end
          default: check_count(prdata[cnt_w-1:0], '0, "unmapped read");
        endcase
      end
      fin_due = 1'b0;
      new_inc_a = 1'b0;
      new_inc_b = 1'b0;
      if (m_busy) begin
        m_left = m_left - 1;
        fin_due = (m_left == 0);
      end
      check_flag(finish_a, fin_due && (m_owner == owner_a), "finish_a");
      check_flag(finish_b, fin_due && (m_owner == owner_b), "finish_b");
      check_flag(reset_start_request_a, fin_due && (m_owner == owner_a), "reset_start_request_a");
      check_flag(reset_start_request_b, fin_due && (m_owner == owner_b), "reset_start_request_b");
      if (fin_due) begin
        if (m_owner == owner_a) begin
          check_data(received_data_a, m_exp, "received_data_a");
        end else begin
          check_data(received_data_b, m_exp, "received_data_b");
        end
        m_busy = 1'b0;
      end else if (!m_busy && m_enable && (start_request_a || start_request_b)) begin
        if (start_request_a && start_request_b) begin
          win = (m_mode == mode_fixed || m_last == owner_b) ? owner_a : owner_b;
        end else begin
          win = start_request_a ? owner_a : owner_b; // lone requester
        end
        m_owner = win;
        m_last = win;
        m_exp = byte_sum((win == owner_a) ? input_arguments_a : input_arguments_b);
        m_busy = 1'b1;
        m_left = engine_cycles + 2;
        new_inc_a = (win == owner_a);
        new_inc_b = (win == owner_b);
      end
      if (apb_wr && (paddr == addr_cnt_a)) begin
        m_cnt_a = '0; // clear beats a grant
      end else if (m_inc_a && (m_cnt_a != '1)) begin
        m_cnt_a = m_cnt_a + 1'b1;
      end
      if (apb_wr && (paddr == addr_cnt_b)) begin
        m_cnt_b = '0;
      end else if (m_inc_b && (m_cnt_b != '1)) begin
        m_cnt_b = m_cnt_b + 1'b1;
      end
      m_inc_a = new_inc_a;
      m_inc_b = new_inc_b;
      if (apb_wr && (paddr == addr_ctrl)) begin
        m_enable = pwdata[0];
        m_mode = pwdata[1];
      end
    end
  end

  initial begin
    sm_clk = 1'b0;
    rst = 1'b1;
    psel = 1'b0;
    penable = 1'b0;
    pwrite = 1'b0;
    paddr = '0;
    pwdata = '0;
    start_request_a = 1'b0;
    start_request_b = 1'b0;
    input_arguments_a = '0;
    input_arguments_b = '0;
    n_err = 0;
    n_tmo = 0;
    lfsr = 32'h994d;
    repeat (4) @(negedge sm_clk);
    rst = 1'b0;
    apb_read(addr_ctrl); // reset values, no requests yet
    apb_read(addr_cnt_a);
    apb_read(addr_cnt_b);
    apb_read(addr_status);
    apb_read(apb_addr_w'(6)); // unmapped address
    repeat (5) @(negedge sm_clk);
    repeat (3) begin
      both_at_once(); // fixed priority
      apb_read(addr_status);
    end
    apb_write(addr_ctrl, 32'd3); // round robin
    repeat (4) begin
      both_at_once();
      apb_read(addr_status);
    end
    fork
      client_stream(owner_a, 12);
      client_stream(owner_b, 12);
    join
    apb_write(addr_ctrl, 32'd1);
    fork
      client_stream(owner_a, 10);
      client_stream(owner_b, 10);
    join
    apb_read(addr_cnt_a);
    apb_read(addr_cnt_b);
    apb_write(addr_ctrl, 32'd0); // request must wait while disabled
    fork
      client_job(owner_a, rand_bits(arg_w));
      begin
        repeat (20) @(negedge sm_clk);
        apb_read(addr_status);
        apb_write(addr_ctrl, 32'd1);
      end
    join
    apb_write(addr_cnt_a, rand_bits(apb_data_w));
    apb_read(addr_cnt_a);
    apb_write(addr_cnt_b, '0);
    apb_read(addr_cnt_b);
    fork
      client_stream(owner_a, 4);
      client_stream(owner_b, 4);
      repeat (6) apb_write(addr_cnt_b, '0); // clears racing grants
    join
    apb_read(addr_cnt_a);
    apb_read(addr_cnt_b);
    apb_read(addr_status);
    repeat (5) @(negedge sm_clk);
    $display("end of run: %0d value errors, %0d timeouts", n_err, n_tmo);
    if (n_err == 0 && n_tmo == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

// File: build.f
source/sc_pkg.sv
source/shared_access_to_one_current_state_machine.sv
source/checksum_engine.sv
source/sm_share_regs.sv
source/sm_share_top.sv
test/sm_share_tb.sv

// File: run_sim.sh
#!/bin/sh
# compile the testbench with verilator, run it and look for the pass line

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f build.f \
  --top-module sm_share_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "compile step failed"
  exit 1
fi

out=$(./obj_dir/Vsm_share_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^Result: PASSED$'; then
  exit 0
fi
echo "pass line not found in simulation output"
exit 1
